//--- all.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/pipestage.sv
hdl/decode_stage_0.sv
hdl/decode_stage_1.sv
hdl/decode_top.sv
tb/decode_tb.sv

//--- hdl/decode_defs.svh
// ****************************************
// Decode block sizing macros
// PC width, fetch window and prefix limit
// ****************************************

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// PC and address width
`define DEC_ADDR_W 32

// Fetch window in bytes, 128 bits wide
`define DEC_WINDOW_BYTES 16

// Longest prefix run scanned ahead of the opcode
`define DEC_MAX_PREFIX 4

`endif

//--- hdl/decode_pkg.sv
// ****************************************
// Decode types: operand kinds, ALU and
// stack ops, and the per-stage structs
// ****************************************

`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

   typedef enum logic [1:0] {
      OPK_NONE = 2'd0,
      OPK_REG  = 2'd1,
      OPK_MEM  = 2'd2,
      OPK_IMM  = 2'd3
   } operand_kind_e;

   // First eight follow opcode bits 5:3 and group 1 ModRM.reg
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_OR  = 4'd1,
      ALU_ADC = 4'd2,
      ALU_SBB = 4'd3,
      ALU_AND = 4'd4,
      ALU_SUB = 4'd5,
      ALU_XOR = 4'd6,
      ALU_CMP = 4'd7,
      ALU_MOV = 4'd8,
      ALU_NOP = 4'd9
   } alu_op_e;

   typedef enum logic [1:0] {
      STK_NONE = 2'd0,
      STK_PUSH = 2'd1,
      STK_POP  = 2'd2
   } stack_op_e;

   // Stage 0 result
   typedef struct packed {
      logic [2:0]             seg_override;
      logic                   seg_override_valid;
      logic                   size_override;
      logic [7:0]             opcode;
      logic                   has_modrm;
      logic [7:0]             modrm;
      logic                   has_sib;
      logic [7:0]             sib;
      logic [31:0]            disp;
      logic [31:0]            imm;
      logic [4:0]             length;
      logic [`DEC_ADDR_W-1:0] pc;
      logic                   branch_taken;
   } fields_t;

   // Stage 1 result, also the block output
   typedef struct packed {
      logic [2:0]             size;
      logic                   set_d_flag;
      logic                   clear_d_flag;
      operand_kind_e          op0;
      operand_kind_e          op1;
      logic [2:0]             op0_reg;
      logic [2:0]             op1_reg;
      logic [7:0]             modrm;
      logic [7:0]             sib;
      logic [31:0]            disp;
      logic [31:0]            imm;
      alu_op_e                alu_op;
      stack_op_e              stack_op;
      logic [2:0]             seg_override;
      logic                   seg_override_valid;
      logic [4:0]             length;
      logic [`DEC_ADDR_W-1:0] pc;
      logic                   branch_taken;
      logic                   invalid;
   } decoded_t;

endpackage

`default_nettype wire

//--- hdl/decode_stage_0.sv
// ****************************************
// Length decode and field extraction
// from the fetch window
// ****************************************

`default_nettype none

`include "decode_defs.svh"

module decode_stage_0 import decode_pkg::*; (
   input  wire                            f_valid,
   output logic                           f_ready,
   output logic [4:0]                     f_bytes_read,
   input  wire [4:0]                      f_valid_bytes,
   input  wire [`DEC_WINDOW_BYTES*8-1:0]  f_instruction,
   input  wire [`DEC_ADDR_W-1:0]          f_pc,
   input  wire                            f_branch_taken,
   input  wire                            flush,
   output logic                           s0_valid,
   input  wire                            s0_ready,
   output fields_t                        s0_fields
);

   logic [2:0]                    npfx;
   logic                          scanning;
   logic [2:0]                    seg;
   logic                          seg_valid;
   logic                          size_ovr;
   logic [7:0]                    opcode;
   logic [7:0]                    modrm;
   logic [7:0]                    sib;
   logic                          alu_fam;
   logic                          grp1;
   logic                          mov_rm;
   logic                          mov_imm;
   logic                          has_modrm;
   logic                          has_sib;
   logic                          imm8;
   logic                          imm_full;
   logic [2:0]                    disp_bytes;
   logic [2:0]                    imm_bytes;
   logic [4:0]                    dpos;
   logic [4:0]                    ipos;
   logic [4:0]                    length;
   logic [`DEC_WINDOW_BYTES*8-1:0] disp_win;
   logic [`DEC_WINDOW_BYTES*8-1:0] imm_win;
   logic [31:0]                   disp;
   logic [31:0]                   imm;
   logic                          fits;

   // Prefix scan, later segment overrides replace earlier ones
   always_comb begin
      npfx      = 3'd0;
      scanning  = 1'b1;
      seg       = 3'd0;
      seg_valid = 1'b0;
      size_ovr  = 1'b0;
      for (int i = 0; i < `DEC_MAX_PREFIX; i++) begin
         if (scanning) begin
            case (f_instruction[8*i +: 8])
               8'h66: begin
                  size_ovr = 1'b1;
                  npfx     = npfx + 3'd1;
               end
               8'h26, 8'h2E, 8'h36, 8'h3E: begin
                  // ES, CS, SS, DS sit in bits 4:3
                  seg       = {1'b0, f_instruction[8*i+3 +: 2]};
                  seg_valid = 1'b1;
                  npfx      = npfx + 3'd1;
               end
               8'h64, 8'h65: begin
                  seg       = {2'b10, f_instruction[8*i]};
                  seg_valid = 1'b1;
                  npfx      = npfx + 3'd1;
               end
               default: scanning = 1'b0;
            endcase
         end
      end
   end

   assign opcode = f_instruction[8*npfx +: 8];
   assign modrm  = f_instruction[8*(npfx+1) +: 8];
   assign sib    = f_instruction[8*(npfx+2) +: 8];

   // Opcode classes
   assign alu_fam = (opcode[7:6] == 2'b00) && (opcode[2:0] <= 3'd5);
   assign grp1    = (opcode == 8'h80) || (opcode == 8'h81) || (opcode == 8'h83);
   assign mov_rm  = (opcode[7:2] == 6'b100010);
   assign mov_imm = (opcode[7:3] == 5'b10111);

   assign has_modrm = (alu_fam && !opcode[2]) || grp1 || mov_rm;
   assign has_sib   = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'd4);

   // AL forms and the byte group 1 ops take imm8
   assign imm8     = (alu_fam && opcode[2] && !opcode[0]) ||
                     (opcode == 8'h80) || (opcode == 8'h83);
   assign imm_full = (alu_fam && opcode[2] && opcode[0]) ||
                     (opcode == 8'h81) || mov_imm;

   always_comb begin
      if (imm8) begin
         imm_bytes = 3'd1;
      end else if (imm_full) begin
         imm_bytes = size_ovr ? 3'd2 : 3'd4;
      end else begin
         imm_bytes = 3'd0;
      end
   end

   always_comb begin
      disp_bytes = 3'd0;
      if (has_modrm) begin
         case (modrm[7:6])
            2'b01: disp_bytes = 3'd1;
            2'b10: disp_bytes = 3'd4;
            2'b00: begin
               // Absolute disp32, or SIB with no base register
               if (modrm[2:0] == 3'd5 || (has_sib && sib[2:0] == 3'd5)) begin
                  disp_bytes = 3'd4;
               end
            end
            default: disp_bytes = 3'd0;
         endcase
      end
   end

   assign dpos   = 5'(npfx) + 5'd1 + 5'(has_modrm) + 5'(has_sib);
   assign ipos   = dpos + 5'(disp_bytes);
   assign length = ipos + 5'(imm_bytes);

   assign disp_win = f_instruction >> (8 * dpos);
   assign imm_win  = f_instruction >> (8 * ipos);

   always_comb begin
      case (disp_bytes)
         3'd1:    disp = {{24{disp_win[7]}}, disp_win[7:0]};
         3'd4:    disp = disp_win[31:0];
         default: disp = 32'd0;
      endcase
   end

   always_comb begin
      case (imm_bytes)
         3'd1:    imm = {{24{imm_win[7]}}, imm_win[7:0]};
         3'd2:    imm = {16'd0, imm_win[15:0]};
         3'd4:    imm = imm_win[31:0];
         default: imm = 32'd0;
      endcase
   end

   // Hold off until the whole instruction is in the window
   assign fits         = (length <= f_valid_bytes);
   assign f_ready      = s0_ready && !flush && fits;
   assign s0_valid     = f_valid && !flush && fits;
   assign f_bytes_read = length;

   always_comb begin
      s0_fields.seg_override       = seg;
      s0_fields.seg_override_valid = seg_valid;
      s0_fields.size_override      = size_ovr;
      s0_fields.opcode             = opcode;
      s0_fields.has_modrm          = has_modrm;
      s0_fields.modrm              = modrm;
      s0_fields.has_sib            = has_sib;
      s0_fields.sib                = sib;
      s0_fields.disp               = disp;
      s0_fields.imm                = imm;
      s0_fields.length             = length;
      s0_fields.pc                 = f_pc;
      s0_fields.branch_taken       = f_branch_taken;
   end

endmodule

`default_nettype wire

//--- hdl/decode_stage_1.sv
// ****************************************
// Operand, register, ALU and stack decode
// of the stage 0 fields
// ****************************************

`default_nettype none

module decode_stage_1 import decode_pkg::*; (
   input  wire       s0_valid,
   output logic      s0_ready,
   input  fields_t   s0_fields,
   output logic      s1_valid,
   input  wire       s1_ready,
   output decoded_t  s1_decoded
);

   logic [7:0]    op;
   logic          alu_fam;
   logic          grp1;
   logic          mov_rm;
   logic          mov_imm;
   operand_kind_e rm_kind;

   // No state here, handshake passes straight through
   assign s1_valid = s0_valid;
   assign s0_ready = s1_ready;

   assign op      = s0_fields.opcode;
   assign alu_fam = (op[7:6] == 2'b00) && (op[2:0] <= 3'd5);
   assign grp1    = (op == 8'h80) || (op == 8'h81) || (op == 8'h83);
   assign mov_rm  = (op[7:2] == 6'b100010);
   assign mov_imm = (op[7:3] == 5'b10111);
   assign rm_kind = (s0_fields.modrm[7:6] == 2'b11) ? OPK_REG : OPK_MEM;

   always_comb begin
      s1_decoded                    = '0;
      s1_decoded.size               = s0_fields.size_override ? 3'd2 : 3'd4;
      s1_decoded.op0                = OPK_NONE;
      s1_decoded.op1                = OPK_NONE;
      s1_decoded.modrm              = s0_fields.has_modrm ? s0_fields.modrm : 8'h00;
      s1_decoded.sib                = s0_fields.has_sib ? s0_fields.sib : 8'h00;
      s1_decoded.disp               = s0_fields.disp;
      s1_decoded.imm                = s0_fields.imm;
      s1_decoded.alu_op             = ALU_NOP;
      s1_decoded.stack_op           = STK_NONE;
      s1_decoded.seg_override       = s0_fields.seg_override;
      s1_decoded.seg_override_valid = s0_fields.seg_override_valid;
      s1_decoded.length             = s0_fields.length;
      s1_decoded.pc                 = s0_fields.pc;
      s1_decoded.branch_taken       = s0_fields.branch_taken;

      if (alu_fam || mov_rm) begin
         if (alu_fam && op[2]) begin
            // AL,imm8 and eAX,imm
            s1_decoded.op0     = OPK_REG;
            s1_decoded.op0_reg = 3'd0;
            s1_decoded.op1     = OPK_IMM;
         end else if (op[1]) begin
            // Direction bit set, reg is the destination
            s1_decoded.op0     = OPK_REG;
            s1_decoded.op0_reg = s0_fields.modrm[5:3];
            s1_decoded.op1     = rm_kind;
            s1_decoded.op1_reg = s0_fields.modrm[2:0];
         end else begin
            s1_decoded.op0     = rm_kind;
            s1_decoded.op0_reg = s0_fields.modrm[2:0];
            s1_decoded.op1     = OPK_REG;
            s1_decoded.op1_reg = s0_fields.modrm[5:3];
         end
         s1_decoded.alu_op = mov_rm ? ALU_MOV : alu_op_e'({1'b0, op[5:3]});
         if (!op[0]) begin
            s1_decoded.size = 3'd1;
         end
      end else if (grp1) begin
         s1_decoded.op0     = rm_kind;
         s1_decoded.op0_reg = s0_fields.modrm[2:0];
         s1_decoded.op1     = OPK_IMM;
         s1_decoded.alu_op  = alu_op_e'({1'b0, s0_fields.modrm[5:3]});
         if (op == 8'h80) begin
            s1_decoded.size = 3'd1;
         end
      end else if (mov_imm) begin
         s1_decoded.op0     = OPK_REG;
         s1_decoded.op0_reg = op[2:0];
         s1_decoded.op1     = OPK_IMM;
         s1_decoded.alu_op  = ALU_MOV;
      end else if (op[7:4] == 4'h5) begin
         // 0x50-0x57 push, 0x58-0x5F pop
         s1_decoded.op0      = OPK_REG;
         s1_decoded.op0_reg  = op[2:0];
         s1_decoded.stack_op = op[3] ? STK_POP : STK_PUSH;
      end else if (op == 8'hFC) begin
         s1_decoded.clear_d_flag = 1'b1;
      end else if (op == 8'hFD) begin
         s1_decoded.set_d_flag = 1'b1;
      end else if (op != 8'h90) begin
         s1_decoded.invalid = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hdl/decode_top.sv
// ****************************************
// Two-stage decode top level
// ****************************************

`default_nettype none

`include "decode_defs.svh"

module decode_top import decode_pkg::*; (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            flush,
   input  wire                            f_valid,
   output logic                           f_ready,
   output logic [4:0]                     f_bytes_read,
   input  wire [4:0]                      f_valid_bytes,
   input  wire [`DEC_WINDOW_BYTES*8-1:0]  f_instruction,
   input  wire [`DEC_ADDR_W-1:0]          f_pc,
   input  wire                            f_branch_taken,
   output logic                           d_valid,
   input  wire                            d_ready,
   output decoded_t                       d_out
);

   logic     s0_valid;
   logic     s0_ready;
   fields_t  s0_fields;
   logic     s0_valid_r;
   logic     s0_ready_r;
   fields_t  s0_fields_r;
   logic     s1_valid;
   logic     s1_ready;
   decoded_t s1_decoded;

   decode_stage_0 ds0 (
      .f_valid        (f_valid),
      .f_ready        (f_ready),
      .f_bytes_read   (f_bytes_read),
      .f_valid_bytes  (f_valid_bytes),
      .f_instruction  (f_instruction),
      .f_pc           (f_pc),
      .f_branch_taken (f_branch_taken),
      .flush          (flush),
      .s0_valid       (s0_valid),
      .s0_ready       (s0_ready),
      .s0_fields      (s0_fields)
   );

   pipestage #(.WIDTH($bits(fields_t))) stage0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (s0_valid),
      .in_ready  (s0_ready),
      .in_data   (s0_fields),
      .out_valid (s0_valid_r),
      .out_ready (s0_ready_r),
      .out_data  (s0_fields_r)
   );

   decode_stage_1 ds1 (
      .s0_valid   (s0_valid_r),
      .s0_ready   (s0_ready_r),
      .s0_fields  (s0_fields_r),
      .s1_valid   (s1_valid),
      .s1_ready   (s1_ready),
      .s1_decoded (s1_decoded)
   );

   pipestage #(.WIDTH($bits(decoded_t))) stage1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (s1_valid),
      .in_ready  (s1_ready),
      .in_data   (s1_decoded),
      .out_valid (d_valid),
      .out_ready (d_ready),
      .out_data  (d_out)
   );

endmodule

`default_nettype wire

//--- hdl/pipestage.sv
// ****************************************
// One-entry valid/ready register slice
// with flush
// ****************************************

`default_nettype none

module pipestage #(
   parameter int WIDTH = 32
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              flush,
   input  wire              in_valid,
   output logic             in_ready,
   input  wire [WIDTH-1:0]  in_data,
   output logic             out_valid,
   input  wire              out_ready,
   output logic [WIDTH-1:0] out_data
);

   logic             valid_q;
   logic             running;
   logic [WIDTH-1:0] data_q;

   // Accept when empty or when the held word leaves this cycle
   assign in_ready  = running && (!valid_q || out_ready);
   assign out_valid = valid_q;
   assign out_data  = data_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         running <= 1'b0;
      end else begin
         running <= 1'b1;
         if (flush) begin
            valid_q <= 1'b0;
         end else if (in_ready) begin
            valid_q <= in_valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data_q <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module decode_tb

./obj_dir/Vdecode_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
   exit 0
fi
exit 1

//--- tb/decode_tb.sv
// ****************************************
// Decode block testbench: clock, fetch
// model, expectation table and checker
// ****************************************

`default_nettype none

`include "decode_defs.svh"

module decode_tb import decode_pkg::*; ();

   localparam int N     = 17;
   localparam int LIMIT = 20 * N + 200;
   localparam logic [`DEC_ADDR_W-1:0] BASE_PC = 32'h0000_1000;

   // Instruction bytes read left to right, len of them
   typedef struct packed {
      logic [119:0]  code;
      logic [4:0]    len;
      alu_op_e       alu_op;
      operand_kind_e op0;
      operand_kind_e op1;
      logic [2:0]    op0_reg;
      logic [2:0]    op1_reg;
      logic [2:0]    size;
      logic [31:0]   disp;
      logic [31:0]   imm;
      stack_op_e     stack_op;
      logic [3:0]    seg;
      logic [2:0]    flags;
      logic [15:0]   modrm_sib;
   } entry_t;

   logic                           clk;
   logic                           rst_n;
   logic                           flush;
   logic                           f_valid;
   logic                           f_ready;
   logic [4:0]                     f_bytes_read;
   logic [4:0]                     f_valid_bytes;
   logic [`DEC_WINDOW_BYTES*8-1:0] f_instruction;
   logic [`DEC_ADDR_W-1:0]         f_pc;
   logic                           f_branch_taken;
   logic                           d_valid;
   logic                           d_ready;
   decoded_t                       d_out;

   entry_t     tbl [N];
   int         offset [N];
   logic [7:0] stream [128];
   int         total;
   int         idx;
   int         pos;
   int         starve;
   int         exp_q [$];
   int         cycles;
   int         seed;
   logic       flushed;
   logic       do_flush;
   logic       after_flush;
   logic       prev_stall;
   decoded_t   prev_out;

   decode_top decode_top_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .f_valid        (f_valid),
      .f_ready        (f_ready),
      .f_bytes_read   (f_bytes_read),
      .f_valid_bytes  (f_valid_bytes),
      .f_instruction  (f_instruction),
      .f_pc           (f_pc),
      .f_branch_taken (f_branch_taken),
      .d_valid        (d_valid),
      .d_ready        (d_ready),
      .d_out          (d_out)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   initial begin
      wait (cycles >= LIMIT);
      $display("Timeout: the table did not drain within %0d cycles", LIMIT);
      $display("Testbench failed");
      $fatal(1);
   end

   task automatic check(input string name, input logic [159:0] actual,
                        input logic [159:0] expected);
      if (actual !== expected) begin
         $display("error %s: got %0h, expected %0h", name, actual, expected);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic load_table();
      int n;
      tbl[0]  = '{120'h01C8, 5'd2, ALU_ADD, OPK_REG, OPK_REG, 3'd0, 3'd1, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'h0, 3'b000, 16'hC800};
      tbl[1]  = '{120'h2B45F8, 5'd3, ALU_SUB, OPK_REG, OPK_MEM, 3'd0, 3'd5, 3'd4,
                  32'hFFFF_FFF8, 32'h0, STK_NONE, 4'h0, 3'b000, 16'h4500};
      tbl[2]  = '{120'h89848B78563412, 5'd7, ALU_MOV, OPK_MEM, OPK_REG, 3'd4, 3'd0, 3'd4,
                  32'h1234_5678, 32'h0, STK_NONE, 4'h0, 3'b000, 16'h848B};
      tbl[3]  = '{120'h247F, 5'd2, ALU_AND, OPK_REG, OPK_IMM, 3'd0, 3'd0, 3'd1,
                  32'h0, 32'h0000_007F, STK_NONE, 4'h0, 3'b000, 16'h0000};
      // Group 1 with a negative imm8
      tbl[4]  = '{120'h83E9F0, 5'd3, ALU_SUB, OPK_REG, OPK_IMM, 3'd1, 3'd0, 3'd4,
                  32'h0, 32'hFFFF_FFF0, STK_NONE, 4'h0, 3'b000, 16'hE900};
      tbl[5]  = '{120'hBE44332211, 5'd5, ALU_MOV, OPK_REG, OPK_IMM, 3'd6, 3'd0, 3'd4,
                  32'h0, 32'h1122_3344, STK_NONE, 4'h0, 3'b000, 16'h0000};
      tbl[6]  = '{120'h53, 5'd1, ALU_NOP, OPK_REG, OPK_NONE, 3'd3, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_PUSH, 4'h0, 3'b000, 16'h0000};
      tbl[7]  = '{120'h5F, 5'd1, ALU_NOP, OPK_REG, OPK_NONE, 3'd7, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_POP, 4'h0, 3'b000, 16'h0000};
      tbl[8]  = '{120'h90, 5'd1, ALU_NOP, OPK_NONE, OPK_NONE, 3'd0, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'h0, 3'b000, 16'h0000};
      tbl[9]  = '{120'hFC, 5'd1, ALU_NOP, OPK_NONE, OPK_NONE, 3'd0, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'h0, 3'b010, 16'h0000};
      tbl[10] = '{120'hFD, 5'd1, ALU_NOP, OPK_NONE, OPK_NONE, 3'd0, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'h0, 3'b100, 16'h0000};
      // Operand size prefix shortens the immediate, zero extended
      tbl[11] = '{120'h66053412, 5'd4, ALU_ADD, OPK_REG, OPK_IMM, 3'd0, 3'd0, 3'd2,
                  32'h0, 32'h0000_1234, STK_NONE, 4'h0, 3'b000, 16'h0000};
      tbl[12] = '{120'h6681C3FFFF, 5'd5, ALU_ADD, OPK_REG, OPK_IMM, 3'd3, 3'd0, 3'd2,
                  32'h0, 32'h0000_FFFF, STK_NONE, 4'h0, 3'b000, 16'hC300};
      // CS then FS, the later one counts
      tbl[13] = '{120'h2E648B03, 5'd4, ALU_MOV, OPK_REG, OPK_MEM, 3'd0, 3'd3, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'hC, 3'b000, 16'h0300};
      tbl[14] = '{120'h36807C240805, 5'd6, ALU_CMP, OPK_MEM, OPK_IMM, 3'd4, 3'd0, 3'd1,
                  32'h0000_0008, 32'h0000_0005, STK_NONE, 4'hA, 3'b000, 16'h7C24};
      tbl[15] = '{120'h0F, 5'd1, ALU_NOP, OPK_NONE, OPK_NONE, 3'd0, 3'd0, 3'd4,
                  32'h0, 32'h0, STK_NONE, 4'h0, 3'b001, 16'h0000};
      // SIB with base 5 and mod 0 takes disp32
      tbl[16] = '{120'h3304AD00010000, 5'd7, ALU_XOR, OPK_REG, OPK_MEM, 3'd0, 3'd4, 3'd4,
                  32'h0000_0100, 32'h0, STK_NONE, 4'h0, 3'b000, 16'h04AD};
      total = 0;
      for (int k = 0; k < N; k++) begin
         offset[k] = total;
         n = int'(tbl[k].len);
         for (int b = 0; b < n; b++) begin
            stream[total + b] = tbl[k].code[8*(n-1-b) +: 8];
         end
         total += n;
      end
   endtask

   task automatic drive_window();
      int avail;
      avail = total - pos;
      if (avail > `DEC_WINDOW_BYTES) begin
         avail = `DEC_WINDOW_BYTES;
      end
      // One byte short of the current instruction
      if (starve > 0 && idx < N) begin
         avail = int'(tbl[idx].len) - 1;
      end
      for (int i = 0; i < `DEC_WINDOW_BYTES; i++) begin
         f_instruction[8*i +: 8] = (pos + i < total) ? stream[pos + i] : 8'h00;
      end
      f_valid_bytes  = 5'(avail);
      f_pc           = BASE_PC + 32'(pos);
      f_branch_taken = idx[0];
   endtask

   task automatic compare_output(input int k);
      entry_t e;
      e = tbl[k];
      check("length", d_out.length, e.len);
      check("alu_op", d_out.alu_op, e.alu_op);
      check("op0", d_out.op0, e.op0);
      check("op1", d_out.op1, e.op1);
      check("op0_reg", d_out.op0_reg, e.op0_reg);
      check("op1_reg", d_out.op1_reg, e.op1_reg);
      check("size", d_out.size, e.size);
      check("disp", d_out.disp, e.disp);
      check("imm", d_out.imm, e.imm);
      check("stack_op", d_out.stack_op, e.stack_op);
      check("seg_override", {d_out.seg_override_valid, d_out.seg_override}, e.seg);
      check("set_d/clear_d/invalid",
            {d_out.set_d_flag, d_out.clear_d_flag, d_out.invalid}, e.flags);
      check("modrm/sib", {d_out.modrm, d_out.sib}, e.modrm_sib);
      check("pc", d_out.pc, BASE_PC + 32'(offset[k]));
      check("branch_taken", d_out.branch_taken, k[0]);
   endtask

   initial begin
      rst_n          = 1'b0;
      flush          = 1'b0;
      f_valid        = 1'b0;
      f_valid_bytes  = 5'd0;
      f_instruction  = '0;
      f_pc           = '0;
      f_branch_taken = 1'b0;
      d_ready        = 1'b0;
      seed           = $urandom(32'h7103);
      idx            = 0;
      pos            = 0;
      starve         = 0;
      flushed        = 1'b0;
      after_flush    = 1'b0;
      prev_stall     = 1'b0;
      prev_out       = '0;
      load_table();

      repeat (7) begin
         @(negedge clk);
         // Whole first instruction offered while reset holds
         drive_window();
         #1;
         check("f_ready", f_ready, 1'b0);
         check("d_valid", d_valid, 1'b0);
      end

      while (idx < N || exp_q.size() != 0) begin
         @(negedge clk);
         rst_n    = 1'b1;
         do_flush = !flushed && idx >= 8 && exp_q.size() >= 2;
         flush    = do_flush;
         if (do_flush) begin
            f_valid = 1'b0;
            d_ready = 1'b0;
         end else begin
            f_valid = (idx < N) && ($urandom() % 4 != 0);
            // Stall the output ahead of the flush so both registers fill
            d_ready = (!flushed && idx >= 8) ? 1'b0 : ($urandom() % 10 >= 3);
         end
         drive_window();
         #1;

         if (do_flush || starve > 0) begin
            check("f_ready", f_ready, 1'b0);
         end
         if (after_flush) begin
            check("d_valid", d_valid, 1'b0);
         end
         if (prev_stall) begin
            check("d_valid", d_valid, 1'b1);
            check("d_out", d_out, prev_out);
         end
         if (d_valid && d_ready) begin
            if (exp_q.size() == 0) begin
               $display("An output appeared with no instruction in flight");
               $display("Testbench failed");
               $fatal(1);
            end else begin
               compare_output(exp_q.pop_front());
            end
         end

         if (starve > 0) begin
            starve--;
         end
         if (f_valid && f_ready) begin
            check("f_bytes_read", f_bytes_read, tbl[idx].len);
            exp_q.push_back(idx);
            pos += int'(f_bytes_read);
            idx++;
            starve = (idx % 4 == 2) ? 3 : 0;
         end

         prev_stall  = d_valid && !d_ready && !do_flush;
         prev_out    = d_out;
         after_flush = do_flush;
         if (do_flush) begin
            // Refetch from the oldest dropped instruction
            idx     = exp_q[0];
            pos     = offset[idx];
            flushed = 1'b1;
            starve  = (idx % 4 == 2) ? 3 : 0;
            exp_q.delete();
         end
      end

      if (flushed) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("The flush was never applied with instructions in flight");
         $display("Testbench failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire
